//--- fpir_muldiv_top.f
rtl/fpir_format_pkg.sv
rtl/fpir_op_pkg.sv
rtl/fpir_type_decoder.sv
rtl/fpir_sig_unit.sv
rtl/fpir_exp_unit.sv
rtl/fpir_muldiv_core.sv
rtl/fpir_arith_resources.sv
rtl/fpir_muldiv_top.sv
sim/fpir_muldiv_tb.sv

//--- Bender.yml
package:
  name: fpir_muldiv

sources:
  - rtl/fpir_format_pkg.sv
  - rtl/fpir_op_pkg.sv
  - rtl/fpir_type_decoder.sv
  - rtl/fpir_sig_unit.sv
  - rtl/fpir_exp_unit.sv
  - rtl/fpir_muldiv_core.sv
  - rtl/fpir_arith_resources.sv
  - rtl/fpir_muldiv_top.sv
  - target: simulation
    files:
      - sim/fpir_muldiv_tb.sv

//--- sim/fpir_muldiv_tb.sv
// FPIR multiply/divide testbench
`timescale 1ns/1ps

module fpir_muldiv_tb;

  import fpir_format_pkg::*;
  import fpir_op_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  fpir_value_t op_a;
  fpir_value_t op_b;
  fpir_op_e    op;
  logic        out_valid;
  fpir_value_t result;

  // Stimulus table with one entry per operation
  fpir_value_t tab_a[$];
  fpir_value_t tab_b[$];
  fpir_op_e    tab_op[$];
  fpir_type_e  tab_type[$];
  int          tab_gap[$];

  // Operations in flight with the oldest at the head
  fpir_value_t exp_q[$];
  int          due_q[$];
  fpir_type_e  typ_q[$];

  int          cycle_cnt;
  logic [31:0] lcg_state;

  fpir_muldiv_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op_a      (op_a),
    .op_b      (op_b),
    .op        (op),
    .out_valid (out_valid),
    .result    (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Rising edge count that the falling edge reads
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ************************************************************************
  // Helpers
  // ************************************************************************

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Guard and overflow fields left at zero
  function automatic fpir_value_t pack_value(fpir_type_e t, logic s, logic [9:0] e,
                                             logic [11:0] m);
    return {t, s, e, m, {(bw_guard+bw_overflow){1'b0}}};
  endfunction

  // Normal operand with the integer bit set and junk in guard and overflow
  function automatic fpir_value_t random_normal();
    logic [31:0] r;
    r = lcg_next();
    return {type_normal, r[31], r[30:21], 1'b1, r[20:10], r[9:5]};
  endfunction

  // Reference model of the arithmetic rules
  function automatic fpir_value_t model_result(fpir_value_t a, fpir_value_t b,
                                               fpir_op_e o);
    fpir_type_e  ta;
    fpir_type_e  tb_type;
    fpir_type_e  rt;
    logic        is_nan;
    logic        is_inf;
    logic        is_zero;
    logic [11:0] ea;
    logic [11:0] eb;
    logic [11:0] e;
    logic [23:0] prod;
    logic [31:0] quo;
    logic [14:0] m;
    ta      = fpir_type_e'(a[pos_type +: bw_fpir_type]);
    tb_type = fpir_type_e'(b[pos_type +: bw_fpir_type]);
    is_nan  = (ta == type_nan) || (tb_type == type_nan);
    if (o == op_mul) begin
      is_nan  = is_nan || (ta == type_zero && tb_type == type_inf)
                       || (ta == type_inf && tb_type == type_zero);
      is_inf  = (ta == type_inf) || (tb_type == type_inf);
      is_zero = (ta == type_zero) || (tb_type == type_zero);
    end else begin
      is_nan  = is_nan || (ta == type_zero && tb_type == type_zero)
                       || (ta == type_inf && tb_type == type_inf);
      is_inf  = (ta == type_inf) || (tb_type == type_zero);
      // Dividing by infinity also gives zero
      is_zero = (ta == type_zero) || (tb_type == type_inf);
    end
    rt = is_nan ? type_nan : is_inf ? type_inf : is_zero ? type_zero : type_normal;
    if (rt != type_normal) begin
      return {rt, {(bw_fpir_value-bw_fpir_type){1'b0}}};
    end
    // Sign-extended exponents
    ea = {{2{a[pos_exp+9]}}, a[pos_exp +: bw_exponent]};
    eb = {{2{b[pos_exp+9]}}, b[pos_exp +: bw_exponent]};
    if (o == op_mul) begin
      prod = a[pos_sig +: bw_significand] * b[pos_sig +: bw_significand];
      m    = prod[23] ? prod[23:9] : prod[22:8];
      e    = ea + eb + (prod[23] ? 12'd1 : 12'd0);
    end else begin
      quo = ({20'b0, a[pos_sig +: bw_significand]} << 15) / b[pos_sig +: bw_significand];
      m   = quo[15] ? quo[15:1] : quo[14:0];
      e   = ea - eb - (quo[15] ? 12'd0 : 12'd1);
    end
    return {type_normal, a[pos_sign] ^ b[pos_sign], e[9:0], m, e[11:10]};
  endfunction

  // ************************************************************************
  // Checking
  // ************************************************************************

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Testbench failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic abort_run(string reason);
    $display("ERROR: %s", reason);
    $display("Testbench failed");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_fields(fpir_value_t act, fpir_value_t exp_v, fpir_type_e typ);
    check_value("result.type", act[pos_type +: bw_fpir_type], typ);
    check_value("result.sign", act[pos_sign], exp_v[pos_sign]);
    check_value("result.exponent", act[pos_exp +: bw_exponent], exp_v[pos_exp +: bw_exponent]);
    check_value("result.significand", act[pos_sig +: bw_significand],
                exp_v[pos_sig +: bw_significand]);
    check_value("result.guard", act[bw_overflow +: bw_guard], exp_v[bw_overflow +: bw_guard]);
    check_value("result.overflow", act[0 +: bw_overflow], exp_v[0 +: bw_overflow]);
    check_value("result", act, exp_v);
  endtask

  // Each pulse must match the oldest operation on its due cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          abort_run("out_valid pulsed with no operation in flight");
        end else begin
          check_value("out_valid cycle", cycle_cnt, due_q[0]);
          check_fields(result, exp_q[0], typ_q[0]);
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
          void'(typ_q.pop_front());
        end
      end else if (exp_q.size() != 0 && cycle_cnt >= due_q[0]) begin
        abort_run("out_valid did not pulse when a result was due");
      end
    end
  end

  // ************************************************************************
  // Stimulus table
  // ************************************************************************

  task automatic add_entry(fpir_value_t a, fpir_value_t b, fpir_op_e o, fpir_type_e t,
                           int gap);
    tab_a.push_back(a);
    tab_b.push_back(b);
    tab_op.push_back(o);
    tab_type.push_back(t);
    tab_gap.push_back(gap);
  endtask

  task automatic build_table();
    fpir_value_t nan_v;
    fpir_value_t inf_v;
    fpir_value_t zero_v;
    fpir_value_t norm_v;
    // Special operands carry junk in their numeric fields
    nan_v  = pack_value(type_nan, 1'b1, 10'd7, 12'h900);
    inf_v  = pack_value(type_inf, 1'b1, 10'd9, 12'hFFF);
    zero_v = pack_value(type_zero, 1'b1, 10'd3, 12'h800);
    norm_v = pack_value(type_normal, 1'b1, 10'd2, 12'hA00);
    // Multiply with the product top bit set and clear
    add_entry(pack_value(type_normal, 1'b1, 10'd3, 12'hC00),
              pack_value(type_normal, 1'b0, 10'h3FE, 12'hC00), op_mul, type_normal, 1);
    add_entry(pack_value(type_normal, 1'b0, 10'd5, 12'h800),
              pack_value(type_normal, 1'b0, 10'd7, 12'h800), op_mul, type_normal, 0);
    add_entry(pack_value(type_normal, 1'b0, 10'd20, 12'hFFF),
              pack_value(type_normal, 1'b1, 10'h3F0, 12'hFFF), op_mul, type_normal, 0);
    add_entry(pack_value(type_normal, 1'b1, 10'd1, 12'h801),
              pack_value(type_normal, 1'b1, 10'd1, 12'h803), op_mul, type_normal, 2);
    // Divide with and without the one-step shift
    add_entry(pack_value(type_normal, 1'b0, 10'd4, 12'hC00),
              pack_value(type_normal, 1'b0, 10'd1, 12'h800), op_div, type_normal, 0);
    add_entry(pack_value(type_normal, 1'b1, 10'd4, 12'h800),
              pack_value(type_normal, 1'b0, 10'd6, 12'hC00), op_div, type_normal, 0);
    add_entry(pack_value(type_normal, 1'b0, 10'h3FF, 12'h801),
              pack_value(type_normal, 1'b1, 10'd9, 12'hFFF), op_div, type_normal, 1);
    add_entry(pack_value(type_normal, 1'b0, 10'd0, 12'hABC),
              pack_value(type_normal, 1'b0, 10'd0, 12'hABC), op_div, type_normal, 0);
    // Special types
    add_entry(nan_v, norm_v, op_mul, type_nan, 0);
    add_entry(norm_v, nan_v, op_div, type_nan, 0);
    add_entry(zero_v, inf_v, op_mul, type_nan, 0);
    add_entry(inf_v, zero_v, op_mul, type_nan, 0);
    add_entry(zero_v, zero_v, op_div, type_nan, 1);
    add_entry(inf_v, inf_v, op_div, type_nan, 0);
    add_entry(norm_v, zero_v, op_div, type_inf, 0);
    add_entry(inf_v, norm_v, op_mul, type_inf, 0);
    add_entry(zero_v, norm_v, op_div, type_zero, 0);
    add_entry(norm_v, zero_v, op_mul, type_zero, 0);
    add_entry(norm_v, inf_v, op_div, type_zero, 2);
    // Large exponents reach the overflow field
    add_entry(pack_value(type_normal, 1'b0, 10'd500, 12'hC00),
              pack_value(type_normal, 1'b0, 10'd500, 12'hC00), op_mul, type_normal, 0);
    add_entry(pack_value(type_normal, 1'b1, 10'h20C, 12'h800),
              pack_value(type_normal, 1'b0, 10'h20C, 12'h800), op_mul, type_normal, 0);
    add_entry(pack_value(type_normal, 1'b0, 10'd500, 12'h800),
              pack_value(type_normal, 1'b0, 10'h20C, 12'hC00), op_div, type_normal, 1);
  endtask

  // ************************************************************************
  // Main sequence
  // ************************************************************************

  initial begin : stimulus
    fpir_value_t ra;
    fpir_value_t rb;
    logic [31:0] r;
    int          timeout;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    op_a        = '0;
    op_b        = '0;
    op          = op_mul;
    cycle_cnt   = 0;
    lcg_state   = 32'h5b1f_501f;
    build_table();
    // Random normal operands follow the directed entries
    for (int i = 0; i < 40; i++) begin
      ra = random_normal();
      rb = random_normal();
      r  = lcg_next();
      add_entry(ra, rb, fpir_op_e'(r[31]), type_normal, r[30] ? 1 : 0);
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("out_valid", out_valid, 32'd0);
    check_value("result", result, 32'd0);
    // Gap 0 gives back-to-back inputs
    for (int i = 0; i < tab_a.size(); i++) begin
      op_a     = tab_a[i];
      op_b     = tab_b[i];
      op       = tab_op[i];
      in_valid = 1'b1;
      exp_q.push_back(model_result(tab_a[i], tab_b[i], tab_op[i]));
      due_q.push_back(cycle_cnt + 2);
      typ_q.push_back(tab_type[i]);
      @(negedge clk);
      in_valid = 1'b0;
      repeat (tab_gap[i]) @(negedge clk);
    end
    // Drain the pipeline
    timeout = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      timeout++;
      if (timeout > 8) begin
        abort_run("results still pending after the last input");
      end
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- rtl/fpir_muldiv_top.sv
// FPIR multiply/divide top level
`timescale 1ns/1ps

module fpir_muldiv_top #(
  parameter int bw_mul_in = fpir_format_pkg::bw_sig_ext + 1,
  parameter int bw_div_in = fpir_format_pkg::bw_sig_ext + 1,
  parameter int bw_add_in = fpir_format_pkg::bw_sig_ext + 1
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid,
  input  fpir_format_pkg::fpir_value_t op_a,
  input  fpir_format_pkg::fpir_value_t op_b,
  input  fpir_op_pkg::fpir_op_e        op,
  output logic                         out_valid,
  output fpir_format_pkg::fpir_value_t result
);

  import fpir_format_pkg::*;
  import fpir_op_pkg::*;

  // Input stage
  fpir_value_t a_q;
  fpir_value_t b_q;
  fpir_op_e    op_q;
  logic        valid_q;
  fpir_value_t core_result;

  // Core to resource wiring
  logic [bw_mul_in-1:0]   mul_a;
  logic [bw_mul_in-1:0]   mul_b;
  logic [2*bw_mul_in-1:0] mul_p;
  logic [bw_div_in-1:0]   div_n;
  logic [bw_div_in-1:0]   div_d;
  logic [bw_div_in-1:0]   div_q;
  logic [bw_add_in-1:0]   add_a;
  logic [bw_add_in-1:0]   add_b;
  logic                   add_sub;
  logic [bw_add_in-1:0]   add_s;

  // ************************************************************************
  // Input register
  // ************************************************************************

  // Operands load only with a valid strobe
  always_ff @(posedge clk) begin
    if (in_valid) begin
      a_q  <= op_a;
      b_q  <= op_b;
      op_q <= op;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  fpir_muldiv_core #(
    .bw_mul_in (bw_mul_in),
    .bw_div_in (bw_div_in),
    .bw_add_in (bw_add_in)
  ) u_core (
    .a       (a_q),
    .b       (b_q),
    .op      (op_q),
    .mul_a   (mul_a),
    .mul_b   (mul_b),
    .mul_p   (mul_p),
    .div_n   (div_n),
    .div_d   (div_d),
    .div_q   (div_q),
    .add_a   (add_a),
    .add_b   (add_b),
    .add_sub (add_sub),
    .add_s   (add_s),
    .result  (core_result)
  );

  fpir_arith_resources #(
    .bw_mul_in (bw_mul_in),
    .bw_div_in (bw_div_in),
    .bw_add_in (bw_add_in)
  ) u_res (
    .mul_a   (mul_a),
    .mul_b   (mul_b),
    .mul_p   (mul_p),
    .div_n   (div_n),
    .div_d   (div_d),
    .div_q   (div_q),
    .add_a   (add_a),
    .add_b   (add_b),
    .add_sub (add_sub),
    .add_s   (add_s)
  );

  // ************************************************************************
  // Result register
  // ************************************************************************

  // Holds the last result between pulses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
    end else begin
      out_valid <= valid_q;
      if (valid_q) begin
        result <= core_result;
      end
    end
  end

endmodule

//--- rtl/fpir_arith_resources.sv
// Shared FPIR arithmetic resources
`timescale 1ns/1ps

module fpir_arith_resources #(
  parameter int bw_mul_in = fpir_format_pkg::bw_sig_ext + 1,
  parameter int bw_div_in = fpir_format_pkg::bw_sig_ext + 1,
  parameter int bw_add_in = fpir_format_pkg::bw_sig_ext + 1
) (
  input  logic [bw_mul_in-1:0]   mul_a,
  input  logic [bw_mul_in-1:0]   mul_b,
  output logic [2*bw_mul_in-1:0] mul_p,
  input  logic [bw_div_in-1:0]   div_n,
  input  logic [bw_div_in-1:0]   div_d,
  output logic [bw_div_in-1:0]   div_q,
  input  logic [bw_add_in-1:0]   add_a,
  input  logic [bw_add_in-1:0]   add_b,
  input  logic                   add_sub,
  output logic [bw_add_in-1:0]   add_s
);

  // ************************************************************************
  // Unsigned multiplier
  // ************************************************************************

  assign mul_p = mul_a * mul_b;

  // ************************************************************************
  // Restoring divider
  // ************************************************************************

  // Fractional divide: q = (n << (bw_div_in-1)) / d
  // Expects n < 2*d, which normalized significands always meet
  // Divide by zero gives all ones
  always_comb begin : restoring_div
    logic [bw_div_in:0] rem;
    rem   = {1'b0, div_n};
    div_q = '0;
    // One compare-and-subtract per quotient bit, MSB first
    for (int i = bw_div_in-1; i >= 0; i--) begin
      if (rem >= {1'b0, div_d}) begin
        div_q[i] = 1'b1;
        rem      = rem - {1'b0, div_d};
      end
      // Bring in the next zero bit of the scaled numerator
      rem = rem << 1;
    end
  end

  // ************************************************************************
  // Adder/subtractor
  // ************************************************************************

  // Two's complement, wraps at bw_add_in
  assign add_s = add_sub ? (add_a - add_b) : (add_a + add_b);

endmodule

//--- rtl/fpir_muldiv_core.sv
// FPIR multiply/divide core
`timescale 1ns/1ps

module fpir_muldiv_core #(
  parameter int bw_mul_in = fpir_format_pkg::bw_sig_ext + 1,
  parameter int bw_div_in = fpir_format_pkg::bw_sig_ext + 1,
  parameter int bw_add_in = fpir_format_pkg::bw_sig_ext + 1
) (
  input  fpir_format_pkg::fpir_value_t a,
  input  fpir_format_pkg::fpir_value_t b,
  input  fpir_op_pkg::fpir_op_e        op,
  output logic [bw_mul_in-1:0]         mul_a,
  output logic [bw_mul_in-1:0]         mul_b,
  input  logic [2*bw_mul_in-1:0]       mul_p,
  output logic [bw_div_in-1:0]         div_n,
  output logic [bw_div_in-1:0]         div_d,
  input  logic [bw_div_in-1:0]         div_q,
  output logic [bw_add_in-1:0]         add_a,
  output logic [bw_add_in-1:0]         add_b,
  output logic                         add_sub,
  input  logic [bw_add_in-1:0]         add_s,
  output fpir_format_pkg::fpir_value_t result
);

  import fpir_format_pkg::*;

  fpir_type_e res_type;
  logic       sign;
  sig_ext_t   sig_ext;
  exp_ext_t   exp_ext;
  logic       norm_shift;

  // Result class from operand types
  fpir_type_decoder u_type (
    .a        (a),
    .b        (b),
    .op       (op),
    .res_type (res_type)
  );

  // Significand path, also reports the normalization step
  fpir_sig_unit #(
    .bw_mul_in (bw_mul_in),
    .bw_div_in (bw_div_in)
  ) u_sig (
    .a          (a),
    .b          (b),
    .op         (op),
    .mul_a      (mul_a),
    .mul_b      (mul_b),
    .mul_p      (mul_p),
    .div_n      (div_n),
    .div_d      (div_d),
    .div_q      (div_q),
    .sign       (sign),
    .sig_ext    (sig_ext),
    .norm_shift (norm_shift)
  );

  // Exponent path follows the significand normalization
  fpir_exp_unit #(
    .bw_add_in (bw_add_in)
  ) u_exp (
    .a          (a),
    .b          (b),
    .op         (op),
    .norm_shift (norm_shift),
    .add_a      (add_a),
    .add_b      (add_b),
    .add_sub    (add_sub),
    .add_s      (add_s),
    .exp_ext    (exp_ext)
  );

  // ************************************************************************
  // Field assembly
  // ************************************************************************

  // Special results carry only the type code
  assign result = (res_type == type_normal)
                ? {res_type, sign, exp_ext[bw_exponent-1:0], sig_ext,
                   exp_ext[bw_exp_ext-1 -: bw_overflow]}
                : {res_type, {(bw_fpir_value-bw_fpir_type){1'b0}}};

endmodule

//--- rtl/fpir_exp_unit.sv
// FPIR exponent unit
`timescale 1ns/1ps

module fpir_exp_unit #(
  parameter int bw_add_in = fpir_format_pkg::bw_sig_ext + 1
) (
  input  fpir_format_pkg::fpir_value_t a,
  input  fpir_format_pkg::fpir_value_t b,
  input  fpir_op_pkg::fpir_op_e        op,
  input  logic                         norm_shift,
  output logic [bw_add_in-1:0]         add_a,
  output logic [bw_add_in-1:0]         add_b,
  output logic                         add_sub,
  input  logic [bw_add_in-1:0]         add_s,
  output fpir_format_pkg::exp_ext_t    exp_ext
);

  import fpir_format_pkg::*;
  import fpir_op_pkg::*;

  localparam logic [bw_add_in-1:0] step = bw_add_in'(norm_shift_max);

  logic [bw_exponent-1:0] a_exp;
  logic [bw_exponent-1:0] b_exp;
  logic [bw_add_in-1:0]   inc;
  logic [bw_add_in-1:0]   dec;
  logic [bw_add_in-1:0]   corr_sum;

  assign a_exp = a[pos_exp +: bw_exponent];
  assign b_exp = b[pos_exp +: bw_exponent];

  // Sign extension to the adder width
  assign add_a   = {{(bw_add_in-bw_exponent){a_exp[bw_exponent-1]}}, a_exp};
  assign add_b   = {{(bw_add_in-bw_exponent){b_exp[bw_exponent-1]}}, b_exp};
  assign add_sub = (op == op_div);

  // Multiply takes +1 by default, the shift case gives it back
  // Divide only loses 1 in the shift case
  assign inc      = (op == op_mul) ? step : '0;
  assign dec      = norm_shift ? step : '0;
  assign corr_sum = add_s + inc - dec;

  // Overflow bits land in the upper part of the extended exponent
  assign exp_ext = corr_sum[bw_exp_ext-1:0];

endmodule

//--- rtl/fpir_sig_unit.sv
// FPIR significand unit
`timescale 1ns/1ps

module fpir_sig_unit #(
  parameter int bw_mul_in = fpir_format_pkg::bw_sig_ext + 1,
  parameter int bw_div_in = fpir_format_pkg::bw_sig_ext + 1
) (
  input  fpir_format_pkg::fpir_value_t a,
  input  fpir_format_pkg::fpir_value_t b,
  input  fpir_op_pkg::fpir_op_e        op,
  output logic [bw_mul_in-1:0]         mul_a,
  output logic [bw_mul_in-1:0]         mul_b,
  input  logic [2*bw_mul_in-1:0]       mul_p,
  output logic [bw_div_in-1:0]         div_n,
  output logic [bw_div_in-1:0]         div_d,
  input  logic [bw_div_in-1:0]         div_q,
  output logic                         sign,
  output fpir_format_pkg::sig_ext_t    sig_ext,
  output logic                         norm_shift
);

  import fpir_format_pkg::*;
  import fpir_op_pkg::*;

  // Product MSB: two zero-extended significands multiplied
  localparam int mul_top = 2*bw_significand - 1;
  // Quotient MSB: the divider scales the numerator by 2^(bw_div_in-1)
  localparam int div_top = bw_div_in - 1;

  logic [bw_significand-1:0] a_sig;
  logic [bw_significand-1:0] b_sig;
  logic                      is_mul;

  assign a_sig  = a[pos_sig +: bw_significand];
  assign b_sig  = b[pos_sig +: bw_significand];
  assign is_mul = (op == op_mul);

  // Result sign; core clears it for non-normal results
  assign sign = a[pos_sign] ^ b[pos_sign];

  // ************************************************************************
  // Operand routing
  // ************************************************************************

  // Idle resource sees zeros so that it does not toggle
  assign mul_a = is_mul ? bw_mul_in'(a_sig) : '0;
  assign mul_b = is_mul ? bw_mul_in'(b_sig) : '0;
  assign div_n = is_mul ? '0 : bw_div_in'(a_sig);
  assign div_d = is_mul ? '0 : bw_div_in'(b_sig);

  // ************************************************************************
  // One-step normalization
  // ************************************************************************

  always_comb begin
    if (is_mul) begin
      // Top bit clear: leading 1 is one place lower
      norm_shift = ~mul_p[mul_top];
      sig_ext    = mul_p[mul_top] ? mul_p[mul_top -: bw_sig_ext]
                                  : mul_p[mul_top-1 -: bw_sig_ext];
    end else begin
      norm_shift = ~div_q[div_top];
      sig_ext    = div_q[div_top] ? div_q[div_top -: bw_sig_ext]
                                  : div_q[div_top-1 -: bw_sig_ext];
    end
  end

endmodule

//--- rtl/fpir_type_decoder.sv
// FPIR result type decoder
`timescale 1ns/1ps

module fpir_type_decoder (
  input  fpir_format_pkg::fpir_value_t a,
  input  fpir_format_pkg::fpir_value_t b,
  input  fpir_op_pkg::fpir_op_e        op,
  output fpir_format_pkg::fpir_type_e  res_type
);

  import fpir_format_pkg::*;
  import fpir_op_pkg::*;

  fpir_type_e a_type;
  fpir_type_e b_type;
  logic       a_zero;
  logic       b_zero;
  logic       a_inf;
  logic       b_inf;

  // Type codes sit in the top field of each operand
  assign a_type = fpir_type_e'(a[pos_type +: bw_fpir_type]);
  assign b_type = fpir_type_e'(b[pos_type +: bw_fpir_type]);

  assign a_zero = (a_type == type_zero);
  assign b_zero = (b_type == type_zero);
  assign a_inf  = (a_type == type_inf);
  assign b_inf  = (b_type == type_inf);

  // Priority order: NaN, then inf, then zero, else normal
  always_comb begin
    if (a_type == type_nan || b_type == type_nan) begin
      res_type = type_nan;
    end else if (op == op_mul) begin
      // 0 x inf is undefined
      if ((a_zero && b_inf) || (a_inf && b_zero)) begin
        res_type = type_nan;
      end else if (a_inf || b_inf) begin
        res_type = type_inf;
      end else if (a_zero || b_zero) begin
        res_type = type_zero;
      end else begin
        res_type = type_normal;
      end
    end else begin
      // 0/0 and inf/inf are undefined
      if ((a_zero && b_zero) || (a_inf && b_inf)) begin
        res_type = type_nan;
      end else if (a_inf || b_zero) begin
        res_type = type_inf;
      end else if (a_zero || b_inf) begin
        res_type = type_zero;  // x/inf also flushes to zero
      end else begin
        res_type = type_normal;
      end
    end
  end

endmodule

//--- rtl/fpir_op_pkg.sv
// FPIR operation definitions
package fpir_op_pkg;

  // ************************************************************************
  // Operation select
  // ************************************************************************

  // One bit is enough for the two operations of this core
  typedef enum logic {
    op_mul = 1'b0,
    op_div = 1'b1
  } fpir_op_e;

  // ************************************************************************
  // Normalization rule
  // ************************************************************************

  // Product of two [1,2) significands lies in [1,4)
  // Quotient of two [1,2) significands lies in (0.5,2)
  // So a single one-bit step always brings the leading 1 to the top
  parameter int norm_shift_max = 1;

endpackage

//--- rtl/fpir_format_pkg.sv
// FPIR format definitions
package fpir_format_pkg;

  // ************************************************************************
  // Field widths
  // ************************************************************************

  // Signed, unbiased exponent
  parameter int bw_exponent = 10;
  // Significand with explicit integer bit at the top
  parameter int bw_significand = 12;
  // Guard bits kept below the significand
  parameter int bw_guard = 3;
  // Extra exponent bits that catch overflow
  parameter int bw_overflow = 2;
  // Type code
  parameter int bw_fpir_type = 2;

  // Combined widths used by the arithmetic path
  parameter int bw_sig_ext = bw_significand + bw_guard;
  parameter int bw_exp_ext = bw_overflow + bw_exponent;

  // Whole value, MSB first: type, sign, exponent, significand, guard, overflow
  parameter int bw_fpir_value = bw_fpir_type + 1 + bw_exponent + bw_sig_ext + bw_overflow;

  // ************************************************************************
  // Field positions (LSB of each field)
  // ************************************************************************

  parameter int pos_sig  = bw_overflow + bw_guard;
  parameter int pos_exp  = pos_sig + bw_significand;
  parameter int pos_sign = pos_exp + bw_exponent;
  parameter int pos_type = pos_sign + 1;

  // Vector types
  typedef logic [bw_fpir_value-1:0] fpir_value_t;
  typedef logic [bw_sig_ext-1:0] sig_ext_t;
  typedef logic [bw_exp_ext-1:0] exp_ext_t;

  // Type code carried in the top field
  typedef enum logic [bw_fpir_type-1:0] {
    type_zero   = 2'd0,
    type_normal = 2'd1,
    type_inf    = 2'd2,
    type_nan    = 2'd3
  } fpir_type_e;

endpackage
